//--- vga_pad_settings.svh
/*
 * timing constants for the gamepad VGA design
 * 640x480 video timing in pixel clocks and lines,
 * plus the NES pad poll slot lengths in pixel clocks
 */

`ifndef VGA_PAD_SETTINGS_SVH
`define VGA_PAD_SETTINGS_SVH

// horizontal timing, in pixel clocks
`define H_DISPLAY 640 // visible width
`define H_FRONT   16  // front porch, right border
`define H_SYNC    96  // sync pulse width
`define H_BACK    48  // back porch, left border

// vertical timing, in lines
`define V_DISPLAY 480 // visible height
`define V_BOTTOM  10  // bottom border
`define V_SYNC    2   // sync pulse lines
`define V_TOP     33  // top border

// gamepad poll slots
// a full slot counts 0 up to PAD_LATCH_CYCLES, so it lasts one cycle more
`define PAD_LATCH_CYCLES 300

// data sample point and pad clock fall within a read slot
`define PAD_HALF_CYCLES  150

`endif

//--- vga_pad_pkg.sv
/*
 * shared types for the gamepad VGA design
 * screen and slot counters, colour levels, button set,
 * colour names and the pad reader states
 */

package vga_pad_pkg;

    typedef logic [9:0]  coord_t;     // screen position
    typedef logic [10:0] pad_count_t; // cycle count within a poll slot
    typedef logic [1:0]  level_t;     // one colour channel

    typedef struct packed {
        level_t r;
        level_t g;
        level_t b;
    } rgb_t;

    // 1 = pressed, fields in pad shift order
    typedef struct packed {
        logic a;
        logic b;
        logic select;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
    } pad_buttons_t;

    typedef enum logic [2:0] {
        black, red, green, blue, yellow, cyan, magenta, white
    } color_t;

    // one latch slot, then one slot per button
    typedef enum logic [3:0] {
        latch_en, read_a, read_b, read_select, read_start,
        read_up, read_down, read_left, read_right
    } pad_state_t;

endpackage

//--- nes_pad_reader.sv
/*
 * NES gamepad reader
 * pulses the latch, clocks out seven more bits and keeps
 * the last sampled level of every button, 1 = pressed
 */

`include "vga_pad_settings.svh"

module nes_pad_reader (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pad_data,  // serial from pad, low = pressed
    output logic                      pad_latch,
    output logic                      pad_clk,
    output vga_pad_pkg::pad_buttons_t buttons
);
    import vga_pad_pkg::*;

    localparam pad_count_t LAST_COUNT = pad_count_t'(`PAD_LATCH_CYCLES);
    localparam pad_count_t HALF_COUNT = pad_count_t'(`PAD_HALF_CYCLES);

    pad_state_t   state;
    pad_count_t   count;
    pad_buttons_t raw;       // bits as shifted in, active low

    logic slot_end;
    logic sample;
    logic clk_high;

    // read_a is a short slot, the bit is already there after the latch
    always_comb begin
        case (state)
            read_a:  slot_end = (count == HALF_COUNT);
            default: slot_end = (count == LAST_COUNT);
        endcase
    end

    assign sample = (state == read_a) ? (count == '0)
                                      : (state != latch_en) && (count == HALF_COUNT);

    // pad clock high for the first half of read_b .. read_right
    assign clk_high = (state >= read_b) && (state <= read_right) && (count <= HALF_COUNT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= latch_en;
            count <= '0;
        end else if (slot_end) begin
            count <= '0;
            if (state >= read_right)
                state <= latch_en;  // poll done, start over
            else
                state <= pad_state_t'(state + 4'd1);
        end else begin
            count <= count + 11'd1;
        end
    end

    // pad lines lag the counter by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
        end else begin
            pad_latch <= (state == latch_en);
            pad_clk   <= clk_high;
        end
    end

    // state picks the button that the current bit belongs to
    always_ff @(posedge clk) begin
        if (reset) begin
            raw <= '1;               // all released
        end else if (sample) begin
            case (state)
                read_a:      raw.a      <= pad_data;
                read_b:      raw.b      <= pad_data;
                read_select: raw.select <= pad_data;
                read_start:  raw.start  <= pad_data;
                read_up:     raw.up     <= pad_data;
                read_down:   raw.down   <= pad_data;
                read_left:   raw.left   <= pad_data;
                read_right:  raw.right  <= pad_data;
                default:     raw        <= raw;
            endcase
        end
    end

    assign buttons = pad_buttons_t'(~raw);

endmodule

//--- vga_sync_gen.sv
/*
 * 640x480 VGA sync generator
 * beam counters, registered sync pulses (high while in the pulse)
 * and the visible area flag
 */

`include "vga_pad_settings.svh"

module vga_sync_gen (
    input  logic clk,
    input  logic reset,
    output logic hsync,
    output logic vsync,
    output logic video_active
);
    import vga_pad_pkg::*;

    localparam coord_t H_SYNC_START = coord_t'(`H_DISPLAY + `H_FRONT);
    localparam coord_t H_SYNC_END   = coord_t'(`H_DISPLAY + `H_FRONT + `H_SYNC - 1);
    localparam coord_t H_MAX =
        coord_t'(`H_DISPLAY + `H_FRONT + `H_SYNC + `H_BACK - 1);

    localparam coord_t V_SYNC_START = coord_t'(`V_DISPLAY + `V_BOTTOM);
    localparam coord_t V_SYNC_END   = coord_t'(`V_DISPLAY + `V_BOTTOM + `V_SYNC - 1);
    localparam coord_t V_MAX =
        coord_t'(`V_DISPLAY + `V_BOTTOM + `V_SYNC + `V_TOP - 1);

    coord_t hpos;
    coord_t vpos;

    logic line_end;

    assign line_end = (hpos == H_MAX);

    always_ff @(posedge clk) begin
        if (reset) begin
            hpos <= '0;
            vpos <= '0;
        end else begin
            if (line_end)
                hpos <= '0;
            else
                hpos <= hpos + 10'd1;

            if (line_end) begin
                if (vpos == V_MAX)
                    vpos <= '0;  // next frame
                else
                    vpos <= vpos + 10'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            hsync <= (hpos >= H_SYNC_START) && (hpos <= H_SYNC_END);
            vsync <= (vpos >= V_SYNC_START) && (vpos <= V_SYNC_END);
        end
    end

    // beam inside the visible 640x480
    assign video_active = (hpos < coord_t'(`H_DISPLAY)) && (vpos < coord_t'(`V_DISPLAY));

endmodule

//--- color_painter.sv
/*
 * screen colour from the gamepad
 * the highest priority pressed button picks the colour, which holds
 * until another press; output is registered and blanked
 */

module color_painter (
    input  logic                      clk,
    input  logic                      reset,
    input  vga_pad_pkg::pad_buttons_t buttons,
    input  logic                      video_active,
    output vga_pad_pkg::rgb_t         rgb
);
    import vga_pad_pkg::*;

    localparam level_t FULL = 2'd3;

    color_t color;
    rgb_t   color_rgb;

    logic has_r;
    logic has_g;
    logic has_b;

    // priority order, up first and select last
    always_ff @(posedge clk) begin
        if (reset)
            color <= black;
        else if (buttons.up)
            color <= red;
        else if (buttons.down)
            color <= green;
        else if (buttons.left)
            color <= blue;
        else if (buttons.right)
            color <= yellow;
        else if (buttons.a)
            color <= cyan;
        else if (buttons.b)
            color <= magenta;
        else if (buttons.start)
            color <= white;
        else if (buttons.select)
            color <= black;
    end

    // which primaries make up each colour
    assign has_r = color inside {red, yellow, magenta, white};
    assign has_g = color inside {green, yellow, cyan, white};
    assign has_b = color inside {blue, cyan, magenta, white};

    assign color_rgb.r = has_r ? FULL : 2'd0;
    assign color_rgb.g = has_g ? FULL : 2'd0;
    assign color_rgb.b = has_b ? FULL : 2'd0;

    always_ff @(posedge clk) begin
        if (reset)
            rgb <= '0;
        else if (video_active)
            rgb <= color_rgb;
        else
            rgb <= '0;   // blank outside the visible area
    end

endmodule

//--- vga_pad_top.sv
/*
 * gamepad controlled VGA colour screen
 * polls an NES pad and fills the visible 640x480 area
 * with the colour of the last pressed button
 */

module vga_pad_top (
    input  logic              clk,       // pixel clock
    input  logic              reset,
    input  logic              pad_data,
    output logic              pad_latch,
    output logic              pad_clk,
    output logic              hsync,
    output logic              vsync,
    output vga_pad_pkg::rgb_t rgb
);
    import vga_pad_pkg::*;

    pad_buttons_t buttons;      // 1 = pressed
    logic         video_active;

    // pad side
    nes_pad_reader i_nes_pad_reader (
        .clk       (clk),
        .reset     (reset),
        .pad_data  (pad_data),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .buttons   (buttons)
    );

    // video timing
    vga_sync_gen i_vga_sync_gen (
        .clk          (clk),
        .reset        (reset),
        .hsync        (hsync),
        .vsync        (vsync),
        .video_active (video_active)
    );

    color_painter i_color_painter (
        .clk          (clk),
        .reset        (reset),
        .buttons      (buttons),
        .video_active (video_active),
        .rgb          (rgb)
    );

endmodule

//--- nes_pad_model.sv
/*
 * behavioural NES gamepad
 * takes the button set on the rising latch and shifts one bit
 * out per rising pad clock, low = pressed, button a first
 */

module nes_pad_model (
    input  logic                      pad_latch,
    input  logic                      pad_clk,
    input  vga_pad_pkg::pad_buttons_t buttons,   // 1 = pressed
    output logic                      pad_data
);

    logic [7:0] shreg = 8'hff;   // all released until the first latch

    // parallel load on the latch, shift on the pad clock
    always @(posedge pad_clk or posedge pad_latch) begin
        if (pad_latch)
            shreg <= ~buttons;
        else
            shreg <= {shreg[6:0], 1'b1};   // a real pad shifts in ones
    end

    assign pad_data = shreg[7];

endmodule

//--- tb_vga_pad_top.sv
/*
 * testbench for the gamepad VGA top level
 * checks reset values, sync and poll timing, colour priority,
 * colour hold and blanking with a pad model on the serial lines
 */

`include "vga_pad_settings.svh"

module tb_vga_pad_top;
    import vga_pad_pkg::*;

    localparam int H_TOTAL = `H_DISPLAY + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_DISPLAY + `V_BOTTOM + `V_SYNC + `V_TOP;
    localparam int FRAME   = H_TOTAL * V_TOTAL;
    localparam int SLOT    = `PAD_LATCH_CYCLES + 1;
    localparam int POLL    = SLOT + (`PAD_HALF_CYCLES + 1) + 7 * SLOT;  // latch, a, seven more

    logic         clk;
    logic         reset;
    logic         pad_data;
    logic         pad_latch;
    logic         pad_clk;
    logic         hsync;
    logic         vsync;
    rgb_t         rgb;
    pad_buttons_t pad_set;   // buttons held down on the model

    int errors = 0;
    int failed_tests = 0;
    int test_count = 0;
    int test_start_errors = 0;

    vga_pad_top i_vga_pad_top (
        .clk       (clk),
        .reset     (reset),
        .pad_data  (pad_data),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb)
    );

    nes_pad_model i_nes_pad_model (
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .buttons   (pad_set),
        .pad_data  (pad_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // nothing visible during the horizontal pulse
    assert property (@(posedge clk) disable iff (reset) hsync |-> rgb == '0)
        else begin
            $display("** Error @ %0t: rgb expected 0, got %h", $time, $sampled(rgb));
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset) !(pad_latch && pad_clk))
        else begin
            $display("pad_clk was high while pad_latch was high at %0t", $time);
            errors++;
        end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
        else begin
            $display("** Error @ %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_idle();
        check_value("pad_latch", 0, pad_latch);
        check_value("pad_clk", 0, pad_clk);
        check_value("hsync", 0, hsync);
        check_value("vsync", 0, vsync);
        check_value("rgb", 0, rgb);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: pass", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAIL with %0d errors", test_count, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    function automatic logic line_level(input int which);
        case (which)
            0:       return hsync;
            1:       return vsync;
            default: return pad_latch;
        endcase
    endfunction

    // high time and rise to rise period, sampled mid cycle
    task automatic measure_pulse(input int which, input string name, input int limit,
                                 output int high_len, output int period);
        int n;
        high_len = 0;
        n = 0;
        @(negedge clk);
        while (line_level(which) && n < limit) begin   // leave a pulse in progress
            @(negedge clk);
            n++;
        end
        while (!line_level(which) && n < limit) begin
            @(negedge clk);
            n++;
        end
        n = 0;
        while (line_level(which) && n < limit) begin
            high_len++;
            @(negedge clk);
            n++;
        end
        period = high_len;
        while (!line_level(which) && n < limit) begin
            period++;
            @(negedge clk);
            n++;
        end
        if (n >= limit) begin
            $display("%s did not finish a pulse within %0d cycles", name, limit);
            errors++;
        end
    endtask

    task automatic load_buttons(input pad_buttons_t pressed);
        @(posedge clk);
        #1 pad_set = pressed;
    endtask

    // one poll per rising latch
    task automatic wait_polls(input int count);
        int n;
        repeat (count) begin
            n = 0;
            @(negedge clk);
            while (pad_latch && n < POLL) begin
                @(negedge clk);
                n++;
            end
            while (!pad_latch && n < 2 * POLL) begin
                @(negedge clk);
                n++;
            end
            if (!pad_latch) begin
                $display("no pad_latch pulse within %0d cycles", 2 * POLL);
                errors++;
            end
        end
    endtask

    function automatic rgb_t make_rgb(input bit r, input bit g, input bit b);
        rgb_t c;
        c.r = r ? 2'd3 : 2'd0;
        c.g = g ? 2'd3 : 2'd0;
        c.b = b ? 2'd3 : 2'd0;
        return c;
    endfunction

    // up first, select last, nothing pressed keeps the old colour
    function automatic rgb_t expected_rgb(input pad_buttons_t pressed, input rgb_t held);
        if (pressed.up)          return make_rgb(1, 0, 0);
        else if (pressed.down)   return make_rgb(0, 1, 0);
        else if (pressed.left)   return make_rgb(0, 0, 1);
        else if (pressed.right)  return make_rgb(1, 1, 0);
        else if (pressed.a)      return make_rgb(0, 1, 1);
        else if (pressed.b)      return make_rgb(1, 0, 1);
        else if (pressed.start)  return make_rgb(1, 1, 1);
        else if (pressed.select) return make_rgb(0, 0, 0);
        return held;
    endfunction

    // a colour is compared over a line from the first lit pixel,
    // black over a whole frame so the visible area is surely covered
    task automatic check_colour(input rgb_t expected);
        int n;
        n = 0;
        @(negedge clk);
        if (expected != '0) begin
            while (rgb == '0 && n < FRAME + H_TOTAL) begin
                @(negedge clk);
                n++;
            end
            if (rgb == '0) begin
                $display("rgb stayed blank for a whole frame at %0t", $time);
                errors++;
            end
        end
        repeat ((expected == '0) ? FRAME : H_TOTAL) begin
            assert (rgb == '0 || rgb == expected)
            else begin
                $display("** Error @ %0t: rgb expected %h, got %h", $time, expected, rgb);
                errors++;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        rgb_t         held;
        pad_buttons_t pressed;
        int           high_len;
        int           period;
        int           pulses;
        int           n;
        logic         last_clk;

        void'($urandom(81));
        reset = 1'b1;
        pad_set = '0;
        held = '0;   // black out of reset

        // reset values
        repeat (10) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_idle();
        n = 0;
        while (!pad_latch && n < 2) begin
            @(negedge clk);
            n++;
        end
        if (!pad_latch) begin
            $display("pad_latch did not rise within two cycles after reset");
            errors++;
        end
        finish_test("reset state");

        measure_pulse(0, "hsync", 2 * H_TOTAL, high_len, period);
        check_value("hsync high cycles", `H_SYNC, high_len);
        check_value("hsync period", H_TOTAL, period);
        measure_pulse(1, "vsync", 2 * FRAME, high_len, period);
        check_value("vsync high cycles", `V_SYNC * H_TOTAL, high_len);
        check_value("vsync period", FRAME, period);
        finish_test("sync timing");

        measure_pulse(2, "pad_latch", 2 * POLL, high_len, period);
        check_value("pad_latch high cycles", SLOT, high_len);
        check_value("pad_latch period", POLL, period);
        n = 0;
        pulses = 0;
        while (pad_latch && n < POLL) begin
            @(negedge clk);
            n++;
        end
        last_clk = pad_clk;
        while (!pad_latch && n < 2 * POLL) begin
            if (pad_clk && !last_clk)
                pulses++;
            last_clk = pad_clk;
            @(negedge clk);
            n++;
        end
        if (!pad_latch) begin
            $display("pad_latch did not come back within %0d cycles", 2 * POLL);
            errors++;
        end
        check_value("pad_clk pulses per poll", 7, pulses);
        finish_test("poll protocol");

        repeat (8) begin
            pressed = pad_buttons_t'(8'($urandom));
            load_buttons(pressed);
            wait_polls(2);
            held = expected_rgb(pressed, held);
            check_colour(held);
        end
        finish_test("colour priority");

        load_buttons('0);   // everything released
        wait_polls(2);
        check_colour(held);
        n = 0;
        repeat (H_TOTAL) begin
            @(negedge clk);
            if (hsync) begin
                check_value("rgb during hsync", 0, rgb);
                n++;
            end
        end
        check_value("hsync cycles in a line", `H_SYNC, n);
        pressed = '0;
        pressed.select = 1'b1;
        load_buttons(pressed);
        wait_polls(2);
        held = expected_rgb(pressed, held);
        check_colour(held);
        finish_test("hold and blanking");

        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
vga_pad_pkg.sv
nes_pad_reader.sv
vga_sync_gen.sv
color_painter.sv
vga_pad_top.sv
nes_pad_model.sv
tb_vga_pad_top.sv
